// File: src/strled_pkg.sv
////////////////////////////////////////////////////////////////////////////
// String LED streamer shared definitions
// Widths, register map, bit positions, interface structs and the
// Wishbone address union used by the register block
////////////////////////////////////////////////////////////////////////////

package strled_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int MEM_AW    = 10;            // Frame-buffer index width
  localparam int MEM_DEPTH = 1 << MEM_AW;   // 1024 bytes
  localparam int PIX_W     = 8;             // Pixel byte
  localparam int CNT_W     = 4;             // Repeat count
  localparam int REG_IDX_W = 2;             // Register index

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [REG_IDX_W-1:0] REG_CONFIG = 2'd0;
  localparam logic [REG_IDX_W-1:0] REG_CTRL   = 2'd1;
  // Indices 2 and 3 are holes, read zero

  // CONFIG bits
  localparam int CFG_EN_BIT     = 31;
  localparam int CFG_IRQ_EN_BIT = 30;

  // CTRL fields
  localparam int CTRL_START_BIT = 31;       // Write-only strobe
  localparam int CTRL_BUSY_BIT  = 29;       // Read-only progress
  localparam int CTRL_COUNT_LSB = 25;       // 4 bits
  localparam int CTRL_LAST_LSB  = 12;       // 10 bits
  localparam int CTRL_FIRST_LSB = 0;        // 10 bits

  ////////////////////////////////////////////////////////////////////////////
  // Bus address, two views of one word
  ////////////////////////////////////////////////////////////////////////////
  // Bit 12 selects the space in both views
  typedef struct packed {
    logic [18:0]          pad_hi;     // Above the decoded range
    logic                 space;      // 0 here
    logic [7:0]           pad_mid;
    logic [REG_IDX_W-1:0] idx;        // Register index
    logic [1:0]           byte_off;   // Ignored
  } strled_reg_addr_t;

  typedef struct packed {
    logic [18:0]       pad_hi;
    logic              space;         // 1 here
    logic [MEM_AW-1:0] idx;           // Frame-buffer byte index
    logic [1:0]        byte_off;
  } strled_mem_addr_t;

  typedef union packed {
    strled_reg_addr_t regs;
    strled_mem_addr_t mem;
  } strled_wb_addr_u;

  ////////////////////////////////////////////////////////////////////////////
  // Block interfaces
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic enable;
    logic irq_en;
  } strled_cfg_t;

  typedef struct packed {
    logic [CNT_W-1:0]  count;         // Extra passes over the window
    logic [MEM_AW-1:0] first;
    logic [MEM_AW-1:0] last;
  } strled_job_t;

  typedef struct packed {
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [PIX_W-1:0]  data;
  } strled_ram_wr_t;

  typedef struct packed {
    logic              re;
    logic [MEM_AW-1:0] addr;
  } strled_ram_rd_t;

endpackage

// File: src/strled_wb_regs.sv
////////////////////////////////////////////////////////////////////////////
// String LED register block
// Wishbone slave with CONFIG and CTRL, frame-buffer write path,
// start strobe and end-of-run interrupt
////////////////////////////////////////////////////////////////////////////

module strled_wb_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  // Wishbone slave
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [31:0]                wb_adr_i,
  input  logic [31:0]                wb_dat_i,
  input  logic [3:0]                 wb_sel_i,
  output logic [31:0]                wb_dat_o,
  output logic                       wb_ack_o,
  output logic                       irq_o,      // End of run pulse
  // To sequencer
  output strled_pkg::strled_cfg_t    cfg_o,
  output strled_pkg::strled_job_t    job_o,
  output logic                       start_o,
  input  logic                       busy_i,
  // To frame buffer
  output strled_pkg::strled_ram_wr_t ram_wr_o
);

  strled_pkg::strled_wb_addr_u adr;
  logic                        req;          // New request, not yet acked
  logic                        reg_hit;
  logic                        mem_hit;
  logic [31:0]                 wmask;        // Per-bit write enable
  logic [31:0]                 cfg_word;
  logic [31:0]                 ctrl_word;
  logic [31:0]                 cfg_next;
  logic [31:0]                 ctrl_next;
  logic [31:0]                 rd_word;

  logic                        ack_q;
  logic                        start_q;
  logic                        irq_q;
  logic                        busy_q;       // Busy one cycle ago
  logic [31:0]                 dat_q;
  strled_pkg::strled_cfg_t     cfg_q;
  strled_pkg::strled_job_t     job_q;
  logic                        ram_we_q;
  logic [strled_pkg::MEM_AW-1:0] ram_addr_q;
  logic [strled_pkg::PIX_W-1:0]  ram_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////
  assign adr     = wb_adr_i;
  assign req     = wb_cyc_i & wb_stb_i & ~ack_q;
  assign reg_hit = req & ~adr.regs.space;
  assign mem_hit = req & adr.mem.space;
  assign wmask   = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}},
                    {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}} & {32{wb_we_i}};

  // Registers laid out at their bus positions
  always_comb begin
    cfg_word                             = '0;
    cfg_word[strled_pkg::CFG_EN_BIT]     = cfg_q.enable;
    cfg_word[strled_pkg::CFG_IRQ_EN_BIT] = cfg_q.irq_en;
  end

  always_comb begin
    ctrl_word = '0;
    ctrl_word[strled_pkg::CTRL_COUNT_LSB +: strled_pkg::CNT_W]  = job_q.count;
    ctrl_word[strled_pkg::CTRL_LAST_LSB  +: strled_pkg::MEM_AW] = job_q.last;
    ctrl_word[strled_pkg::CTRL_FIRST_LSB +: strled_pkg::MEM_AW] = job_q.first;
  end

  // Merge written lanes over current contents
  assign cfg_next  = (cfg_word  & ~wmask) | (wb_dat_i & wmask);
  assign ctrl_next = (ctrl_word & ~wmask) | (wb_dat_i & wmask);

  // Read mux, memory space and holes read zero
  always_comb begin
    rd_word = '0;
    if (!adr.regs.space) begin
      case (adr.regs.idx)
        strled_pkg::REG_CONFIG: rd_word = cfg_word;
        strled_pkg::REG_CTRL: begin
          rd_word                            = ctrl_word;  // Start reads 0
          rd_word[strled_pkg::CTRL_BUSY_BIT] = busy_i;
        end
        default: rd_word = '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q    <= 1'b0;
      start_q  <= 1'b0;
      irq_q    <= 1'b0;
      busy_q   <= 1'b0;
      dat_q    <= '0;
      cfg_q    <= '0;
      job_q    <= '0;
      ram_we_q <= 1'b0;
    end else begin
      ack_q    <= req;                                   // One cycle later
      ram_we_q <= mem_hit & wb_we_i & wb_sel_i[0];       // Low byte only
      start_q  <= reg_hit && (adr.regs.idx == strled_pkg::REG_CTRL) &&
                  wmask[strled_pkg::CTRL_START_BIT] &&
                  wb_dat_i[strled_pkg::CTRL_START_BIT];
      if (req) begin
        dat_q <= rd_word;                                // Valid with ack
      end
      if (reg_hit && (adr.regs.idx == strled_pkg::REG_CONFIG)) begin
        cfg_q.enable <= cfg_next[strled_pkg::CFG_EN_BIT];
        cfg_q.irq_en <= cfg_next[strled_pkg::CFG_IRQ_EN_BIT];
      end
      if (reg_hit && (adr.regs.idx == strled_pkg::REG_CTRL)) begin
        job_q.count <= ctrl_next[strled_pkg::CTRL_COUNT_LSB +: strled_pkg::CNT_W];
        job_q.last  <= ctrl_next[strled_pkg::CTRL_LAST_LSB  +: strled_pkg::MEM_AW];
        job_q.first <= ctrl_next[strled_pkg::CTRL_FIRST_LSB +: strled_pkg::MEM_AW];
      end
      // Falling busy with enable still set marks a completed run
      busy_q <= busy_i;
      irq_q  <= cfg_q.irq_en & cfg_q.enable & busy_q & ~busy_i;
    end
  end

  // Write payload
  always_ff @(posedge clk) begin
    if (mem_hit) begin
      ram_addr_q <= adr.mem.idx;
      ram_data_q <= wb_dat_i[strled_pkg::PIX_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////
  assign wb_ack_o      = ack_q;
  assign wb_dat_o      = dat_q;
  assign irq_o         = irq_q;
  assign cfg_o         = cfg_q;
  assign job_o         = job_q;
  assign start_o       = start_q;
  assign ram_wr_o.we   = ram_we_q;
  assign ram_wr_o.addr = ram_addr_q;
  assign ram_wr_o.data = ram_data_q;

endmodule

// File: src/strled_frame_ram.sv
////////////////////////////////////////////////////////////////////////////
// String LED frame buffer
// Inferred byte array, write port from the bus side and a
// registered read port for the sequencer
////////////////////////////////////////////////////////////////////////////

module strled_frame_ram (
  input  logic                       clk,
  input  strled_pkg::strled_ram_wr_t wr_i,
  input  strled_pkg::strled_ram_rd_t rd_i,
  output logic [strled_pkg::PIX_W-1:0] rdata_o
);

  // Pixel storage
  logic [strled_pkg::PIX_W-1:0] mem [strled_pkg::MEM_DEPTH];
  logic [strled_pkg::PIX_W-1:0] rdata_q;

  // Write port
  always_ff @(posedge clk) begin
    if (wr_i.we) begin
      mem[wr_i.addr] <= wr_i.data;
    end
  end

  // Read port, data one cycle after re
  always_ff @(posedge clk) begin
    if (rd_i.re) begin
      rdata_q <= mem[rd_i.addr];
    end
  end

  assign rdata_o = rdata_q;   // Holds until next re

endmodule

// File: src/strled_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// String LED bit sequencer
// Walks the byte window of the frame buffer, repeats it count
// extra times and shifts each byte out MSB first under ready
////////////////////////////////////////////////////////////////////////////

module strled_sequencer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  strled_pkg::strled_cfg_t      cfg_i,
  input  strled_pkg::strled_job_t      job_i,
  input  logic                         start_i,
  output logic                         busy_o,
  // Frame buffer read
  output strled_pkg::strled_ram_rd_t   rd_o,
  input  logic [strled_pkg::PIX_W-1:0] rdata_i,
  // Bit stream
  output logic                         bit_o,
  output logic                         valid_o,
  input  logic                         ready_i
);

  // Bit states have bit 3 set, low bits give the bit position
  typedef enum logic [3:0] {
    ST_IDLE = 4'h0,
    ST_REQ  = 4'h1,   // Read request
    ST_WAIT = 4'h2,   // Buffer latency
    ST_LOAD = 4'h3,   // Capture byte
    ST_BIT0 = 4'h8,
    ST_BIT1 = 4'h9,
    ST_BIT2 = 4'hA,
    ST_BIT3 = 4'hB,
    ST_BIT4 = 4'hC,
    ST_BIT5 = 4'hD,
    ST_BIT6 = 4'hE,
    ST_BIT7 = 4'hF
  } state_e;

  state_e                        state_q;
  logic [strled_pkg::MEM_AW-1:0] idx_q;      // Byte being sent
  logic [strled_pkg::MEM_AW-1:0] first_q;    // Latched window
  logic [strled_pkg::MEM_AW-1:0] last_q;
  logic [strled_pkg::CNT_W-1:0]  count_q;    // Passes still to go
  logic [strled_pkg::PIX_W-1:0]  hold_q;     // Byte on the wire

  ////////////////////////////////////////////////////////////////////////////
  // Run FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
      first_q <= '0;
      last_q  <= '0;
      count_q <= '0;
    end else if (!cfg_i.enable) begin
      state_q <= ST_IDLE;                  // Abort
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            idx_q   <= job_i.first;
            first_q <= job_i.first;
            last_q  <= job_i.last;
            count_q <= job_i.count;
            state_q <= ST_REQ;
          end
        end
        ST_REQ:  state_q <= ST_WAIT;
        ST_WAIT: state_q <= ST_LOAD;
        ST_LOAD: state_q <= ST_BIT7;
        ST_BIT7, ST_BIT6, ST_BIT5, ST_BIT4,
        ST_BIT3, ST_BIT2, ST_BIT1: begin
          if (ready_i) begin
            state_q <= state_e'(state_q - 4'd1);   // Next lower bit
          end
        end
        ST_BIT0: begin
          if (ready_i) begin
            if (idx_q != last_q) begin
              idx_q   <= idx_q + 1'b1;
              state_q <= ST_REQ;
            end else begin
              idx_q <= first_q;                    // Wrap window
              if (count_q == '0) begin
                state_q <= ST_IDLE;                // Run done
              end else begin
                count_q <= count_q - 1'b1;
                state_q <= ST_REQ;
              end
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Byte capture from the registered read
  always_ff @(posedge clk) begin
    if (state_q == ST_LOAD) begin
      hold_q <= rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////
  assign busy_o    = (state_q != ST_IDLE);
  assign rd_o.re   = (state_q == ST_REQ);
  assign rd_o.addr = idx_q;
  assign valid_o   = state_q[3];
  assign bit_o     = valid_o & hold_q[state_q[2:0]];   // Zero outside bits

endmodule

// File: src/strled_top.sv
////////////////////////////////////////////////////////////////////////////
// String LED frame streamer
// Wishbone registers, frame buffer and bit sequencer
////////////////////////////////////////////////////////////////////////////

module strled_top (
  input  logic        clk,
  input  logic        rst_n,
  // Wishbone slave
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        irq_o,
  // Bit stream to line encoder
  output logic        bit_o,
  output logic        valid_o,
  input  logic        ready_i
);

  strled_pkg::strled_cfg_t      cfg;
  strled_pkg::strled_job_t      job;
  strled_pkg::strled_ram_wr_t   ram_wr;
  strled_pkg::strled_ram_rd_t   ram_rd;
  logic [strled_pkg::PIX_W-1:0] ram_rdata;
  logic                         start;
  logic                         busy;

  strled_wb_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .irq_o    (irq_o),
    .cfg_o    (cfg),
    .job_o    (job),
    .start_o  (start),
    .busy_i   (busy),
    .ram_wr_o (ram_wr)
  );

  strled_frame_ram u_ram (
    .clk     (clk),
    .wr_i    (ram_wr),
    .rd_i    (ram_rd),
    .rdata_o (ram_rdata)
  );

  strled_sequencer u_seq (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg_i   (cfg),
    .job_i   (job),
    .start_i (start),
    .busy_o  (busy),
    .rd_o    (ram_rd),
    .rdata_i (ram_rdata),
    .bit_o   (bit_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

endmodule

// File: bench/tb_strled_top.sv
////////////////////////////////////////////////////////////////////////////
// String LED streamer testbench
// Bus tasks, bit collector under random ready, shadow-buffer model
// and a table of runs applied in a loop
////////////////////////////////////////////////////////////////////////////

module tb_strled_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          TIMEOUT  = 4000;       // Cycles per wait
  localparam logic [31:0] ADR_CFG  = 32'h0;
  localparam logic [31:0] ADR_CTRL = 32'h4;
  localparam logic [31:0] MEM_BASE = 32'h1000;   // Space bit 12

  typedef struct packed {
    logic [9:0] first;
    logic [9:0] last;
    logic [3:0] count;
    logic       irq_en;
    logic       stop;                            // Clear enable mid-run
  } case_t;

  case_t cases [5] = '{
    {10'd0,    10'd3,    4'd0, 1'b1, 1'b0},      // Short window, irq on
    {10'd10,   10'd10,   4'd0, 1'b0, 1'b0},      // Single byte
    {10'd20,   10'd24,   4'd2, 1'b1, 1'b0},
    {10'd1020, 10'd1023, 4'd1, 1'b0, 1'b0},      // Top of buffer
    {10'd40,   10'd47,   4'd3, 1'b1, 1'b1}
  };

  logic        clk, rst_n;
  logic        wb_cyc_i, wb_stb_i, wb_we_i, ready_i;
  logic [31:0] wb_adr_i, wb_dat_i, wb_dat_o;
  logic [3:0]  wb_sel_i;
  logic        wb_ack_o, irq_o, bit_o, valid_o;
  logic [7:0]  shadow [1024];                    // Model of the buffer
  logic        got_q [$];
  logic        exp_q [$];
  integer      seed = 94;
  int          errors, checks, tests, irq_seen;

  strled_top u_strled_top (
    .clk (clk), .rst_n (rst_n),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
    .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o), .irq_o (irq_o),
    .bit_o (bit_o), .valid_o (valid_o), .ready_i (ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                      // 40 ns
  end

  // Ready set on the falling edge, then note what the next rising edge takes
  initial begin
    ready_i = 1'b0;
    forever begin
      @(negedge clk);
      ready_i = (($random(seed) & 255) < 179);   // About 70 % high
      if (valid_o && ready_i) got_q.push_back(bit_o);
      if (irq_o) irq_seen++;
    end
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string why);
    $display("Timeout at %0t ns: %s", $time, why);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic report(input string name, input int base);
    tests++;
    $display("test %0d %-24s %0d errors", tests, name, errors - base);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////////////////////////////////////////
  task automatic wb_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, output logic [31:0] rdat);
    int n;
    n = 0;
    @(negedge clk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_on_timeout("no Wishbone ack");
    end while (!wb_ack_o);
    rdat     = wb_dat_o;                         // Valid in the ack cycle
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    wb_cycle(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    wb_cycle(1'b0, adr, 32'h0, 4'hF, dat);
  endtask

  function automatic logic [31:0] ctrl_word(input logic start, input case_t c);
    logic [31:0] w;
    w = '0;
    w[strled_pkg::CTRL_START_BIT]       = start;
    w[strled_pkg::CTRL_COUNT_LSB +: 4]  = c.count;
    w[strled_pkg::CTRL_LAST_LSB  +: 10] = c.last;
    w[strled_pkg::CTRL_FIRST_LSB +: 10] = c.first;
    return w;
  endfunction

  // Window played count plus 1 times, each byte MSB first
  task automatic build_expected(input case_t c);
    exp_q.delete();
    for (int p = 0; p <= c.count; p++)
      for (int a = c.first; a <= c.last; a++)
        for (int b = 7; b >= 0; b--)
          exp_q.push_back(shadow[a][b]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [31:0] prev;
    logic [7:0]  px;
    case_t       c;
    int          base;
    int          n;
    rst_n    = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    base = errors;
    check("ack after reset", wb_ack_o, 0);
    check("valid after reset", valid_o, 0);
    check("irq after reset", irq_o, 0);
    wb_read(ADR_CFG, rd);
    check("CONFIG after reset", rd, 0);
    wb_read(ADR_CTRL, rd);
    check("CTRL after reset", rd, 0);
    report("reset state", base);

    base = errors;
    wb_write(ADR_CFG, 32'hFFFF_FFFF, 4'hF);
    wb_read(ADR_CFG, rd);
    check("CONFIG readback", rd, 32'hC000_0000);  // Only enable and irq_en
    wb_write(ADR_CFG, 32'h0, 4'b0111);             // Lanes miss bits 31:30
    wb_read(ADR_CFG, rd);
    check("CONFIG partial sel", rd, 32'hC000_0000);
    wb_write(ADR_CFG, 32'h0, 4'b1000);
    wb_write(ADR_CTRL, 32'h7FFF_FFFF, 4'hF);
    wb_read(ADR_CTRL, rd);
    check("CTRL all fields", rd, ctrl_word(1'b0, {10'h3FF, 10'h3FF, 4'hF, 2'b0}));
    prev = ctrl_word(1'b0, {10'h2AB, 10'h123, 4'd5, 2'b0});
    wb_write(ADR_CTRL, prev | 32'h8000_0000, 4'b0111);   // Lane 3 off, count stays F
    wb_write(ADR_CTRL, 32'hFFFF_FF55, 4'b0001);
    wb_read(ADR_CTRL, rd);
    check("CTRL byte lanes", rd, ctrl_word(1'b0, {10'h255, 10'h123, 4'hF, 2'b0}));
    wb_read(MEM_BASE | 32'h14, rd);
    check("memory read", rd, 0);
    wb_read(32'h8, rd);
    check("register hole", rd, 0);
    report("register readback", base);

    for (int r = 0; r < 5; r++) begin
      base = errors;
      c    = cases[r];
      for (int a = c.first; a <= c.last; a++) begin
        px        = a * 13 + (a >> 8) * 71 + r * 17;   // Whole index feeds it
        shadow[a] = px;
        wb_write(MEM_BASE | (a << 2), {24'hA5A5A5, px}, 4'b0001);
      end
      wb_write(ADR_CFG, {1'b1, c.irq_en, 30'b0}, 4'hF);
      got_q.delete();
      irq_seen = 0;
      wb_write(ADR_CTRL, ctrl_word(1'b1, c), 4'hF);
      wb_read(ADR_CTRL, rd);
      check("busy during run", rd[strled_pkg::CTRL_BUSY_BIT], 1);
      n = 0;
      if (c.stop) begin
        while (got_q.size() < 12) begin          // Let the stream get going
          @(negedge clk);
          n++;
          if (n > TIMEOUT) abort_on_timeout("stream never started");
        end
        wb_write(ADR_CFG, {1'b0, c.irq_en, 30'b0}, 4'hF);
        repeat (30) begin
          @(negedge clk);
          check("valid after stop", valid_o, 0);
        end
      end else begin
        do begin
          wb_read(ADR_CTRL, rd);
          n++;
          if (n > TIMEOUT) abort_on_timeout("run never finished");
        end while (rd[strled_pkg::CTRL_BUSY_BIT]);
        build_expected(c);
        check("stream length", got_q.size(), exp_q.size());
        for (int k = 0; k < exp_q.size() && k < got_q.size(); k++)
          check($sformatf("bit %0d", k), got_q[k], exp_q[k]);
      end
      repeat (4) @(negedge clk);                 // Room for the irq pulse
      wb_read(ADR_CTRL, rd);
      check("busy after run", rd[strled_pkg::CTRL_BUSY_BIT], 0);
      check("irq pulses", irq_seen, (c.irq_en && !c.stop) ? 1 : 0);
      report($sformatf("run row %0d", r), base);
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: vlog.f
src/strled_pkg.sv
src/strled_wb_regs.sv
src/strled_frame_ram.sv
src/strled_sequencer.sv
src/strled_top.sv
bench/tb_strled_top.sv

// File: Bender.yml
package:
  name: strled

sources:
  - src/strled_pkg.sv
  - src/strled_wb_regs.sv
  - src/strled_frame_ram.sv
  - src/strled_sequencer.sv
  - src/strled_top.sv
  - target: test
    files:
      - bench/tb_strled_top.sv
